// File: Makefile
BIN := obj_dir/Vtb_intr_unit

all: run

$(BIN): project.f $(wildcard verilog/*.sv sim/*.sv)
	verilator --binary --timing --assert --top-module tb_intr_unit -f project.f

run: $(BIN)
	./$(BIN) | tee sim.log
	@if grep -q "TESTS FAILED" sim.log; then exit 1; fi
	@grep -q "TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean

// File: project.f
verilog/intr_pkg.sv
verilog/io_pkg.sv
verilog/intr_cmd_if.sv
verilog/intr_decode.sv
verilog/intr_regs.sv
verilog/intr_vector.sv
verilog/chan_irq_rx.sv
verilog/intr_unit.sv
sim/tb_intr_unit.sv

// File: sim/tb_intr_unit.sv
// testbench for the interrupt unit
// directed tests against a reference model of rz, rm and rp
`timescale 1ns/1ps

module tb_intr_unit import intr_pkg::*, io_pkg::*; ();

	localparam int DOK = 3; // bus ack delay under test
	localparam int TIMEOUT = 20; // cycles allowed per wait

	logic __clk;
	logic rst_n;
	logic op_strobe;
	intr_op_t op_code;
	word_t w;
	logic [0:HW_N-1] hw_irq;
	logic io_strobe;
	io_word_t io_data;
	logic io_ack, irq, vec_valid, vec_empty;
	user_rz_t bus_rz;
	mask_t mask;
	src_num_t vec_num;

	src_vec_t m_rz, m_rp; // model requests and service levels
	mask_t m_rm; // model mask
	logic [31:0] lfsr;
	int errors;

	intr_unit #(.DOK_TICKS(DOK)) DUT (
		.__clk(__clk), .rst_n(rst_n),
		.op_strobe(op_strobe), .op_code(op_code), .w(w), .hw_irq(hw_irq),
		.io_strobe(io_strobe), .io_data(io_data), .io_ack(io_ack),
		.irq(irq), .bus_rz(bus_rz), .mask(mask),
		.vec_valid(vec_valid), .vec_empty(vec_empty), .vec_num(vec_num)
	);

	always #4 __clk = ~__clk; // 8 ns period

	function automatic logic [31:0] lfsr_next(logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1); // galois form shifting right
	endfunction

	// one lfsr step per bit taken
	task automatic rand_word(output word_t r);
		for (int i = 0; i < 16; i++) begin
			lfsr = lfsr_next(lfsr);
			r[i] = lfsr[0];
		end
	endtask

	// four lfsr bits for a channel number
	task automatic rand_chan(output chan_num_t c);
		for (int i = 0; i < 4; i++) begin
			lfsr = lfsr_next(lfsr);
			c[i] = lfsr[0];
		end
	endtask

	// rm bit covering a source in 1..31
	function automatic int grp_of(int s);
		if (s <= 4) return s - 1; // 1..4 each have their own bit
		if (s <= 11) return 4;
		if (s <= 13) return 5;
		if (s <= 15) return 6;
		if (s <= 21) return 7;
		if (s <= 27) return 8;
		return 9;
	endfunction

	function automatic logic enabled(int s);
		if (s == 0) return 1'b1; // power fail
		return m_rm[grp_of(s)];
	endfunction

	// highest pending unmasked source above every service level or -1
	function automatic int model_pick();
		for (int s = 0; s < 32; s++) begin
			if (m_rp[s]) return -1;
			if (m_rz[s] && enabled(s)) return s;
		end
		return -1;
	endfunction

	function automatic logic model_irq();
		logic any;
		any = 1'b0;
		for (int s = 0; s < 32; s++) begin
			if (m_rz[s] && enabled(s)) any = 1'b1;
		end
		return any;
	endfunction

	function automatic user_rz_t user_view(src_vec_t v);
		return {v[0:11], v[28:31]}; // channels not visible
	endfunction

	function automatic int hw_src(int i);
		return (i < 3) ? i : i + 1; // source 3 only comes from the bus
	endfunction

	function automatic int report_src(io_word_t d);
		if (d[15]) return d[0] ? 29 : 3; // other cpu report at low or high level
		return 12 + int'(d[11:14]);
	endfunction

	task automatic check_vec(string name, src_num_t got, src_num_t exp);
		if (got !== exp) begin
			errors++;
			$display("FAILED %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_mask(string name, mask_t got, mask_t exp);
		if (got !== exp) begin
			errors++;
			$display("FAILED %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_rz(string name, user_rz_t got, user_rz_t exp);
		if (got !== exp) begin
			errors++;
			$display("FAILED %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_bit(string name, logic got, logic exp);
		if (got !== exp) begin
			errors++;
			$display("FAILED %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_count(string name, int got, int exp);
		if (got != exp) begin
			errors++;
			$display("FAILED %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_state();
		check_rz("bus_rz", bus_rz, user_view(m_rz));
		check_mask("mask", mask, m_rm);
		check_bit("irq", irq, model_irq());
	endtask

	// strobe sampled on the rising edge between the two falling edges
	task automatic cpu_op(intr_op_t op, word_t d);
		@(negedge __clk);
		op_strobe = 1'b1;
		op_code = op;
		w = d;
		@(negedge __clk);
		op_strobe = 1'b0;
	endtask

	task automatic load_mask(word_t d);
		cpu_op(OP_LOAD_MASK, d);
		m_rm = d[0:9];
		@(negedge __clk); // regs updated at k+1
		check_state();
	endtask

	task automatic write_rz(word_t d);
		cpu_op(OP_WRITE_RZ, d);
		m_rz[0:11] = d[0:11];
		m_rz[11] = 1'b0; // unused source
		m_rz[28:31] = d[12:15];
		@(negedge __clk);
		check_state();
	endtask

	task automatic soft_int(word_t d);
		cpu_op(OP_SOFT_INT, d);
		m_rz[30] = m_rz[30] | d[14];
		m_rz[31] = m_rz[31] | d[15];
		@(negedge __clk);
		check_state();
	endtask

	task automatic ret_op();
		int s;
		cpu_op(OP_RETURN, '0);
		s = 0;
		while (s < 32 && !m_rp[s]) s++;
		if (s < 32) m_rp[s] = 1'b0; // top level released
		@(negedge __clk);
		check_state();
	endtask

	task automatic accept_op();
		int sel;
		int n;
		sel = model_pick();
		if (sel >= 0) begin
			m_rp[sel] = 1'b1;
			m_rz[sel] = 1'b0;
			for (int s = sel; s < 32; s++) begin
				if (s > 0) m_rm[grp_of(s)] = 1'b0; // accepted group and below
			end
		end
		cpu_op(OP_ACCEPT, '0);
		n = 1; // edge k already passed
		while (!vec_valid && n < TIMEOUT) begin
			@(negedge __clk);
			n++;
		end
		if (!vec_valid) begin
			errors++;
			$display("no vector strobe after an accept");
		end else begin
			check_count("vec_valid latency", n - 1, 2);
			check_bit("vec_empty", vec_empty, sel < 0);
			check_vec("vec_num", vec_num, (sel < 0) ? '0 : src_num_t'(sel));
		end
		check_state();
	endtask

	// one-cycle pulse on a level input
	task automatic raise_hw(int idx);
		@(negedge __clk);
		hw_irq[idx] = 1'b1;
		@(negedge __clk);
		hw_irq[idx] = 1'b0;
		m_rz[hw_src(idx)] = 1'b1;
		check_state();
	endtask

	task automatic io_report(io_word_t d);
		int n;
		@(negedge __clk);
		io_strobe = 1'b1;
		io_data = d;
		@(negedge __clk);
		io_strobe = 1'b0;
		n = 1;
		while (!io_ack && n < TIMEOUT) begin
			@(negedge __clk);
			n++;
		end
		if (!io_ack) begin
			errors++;
			$display("no io_ack after an I/O report");
		end else begin
			check_count("io_ack latency", n - 1, DOK);
		end
		m_rz[report_src(d)] = 1'b1; // set on the ack edge
		check_state();
	endtask

	task automatic test_reset();
		word_t r;
		check_bit("irq", irq, 1'b0);
		check_bit("vec_valid", vec_valid, 1'b0);
		check_bit("io_ack", io_ack, 1'b0);
		check_rz("bus_rz", bus_rz, '0);
		check_mask("mask", mask, '0);
		rand_word(r);
		load_mask(r);
	endtask

	task automatic test_write_rz();
		word_t r;
		repeat (4) begin
			rand_word(r);
			write_rz(r);
		end
		write_rz('0);
		load_mask('0);
		soft_int(16'h0001); // w bit 15 sets the low soft level
		check_bit("irq", irq, 1'b0); // group 9 masked
		load_mask(16'h0040); // group 9 only
		check_bit("irq", irq, 1'b1);
		write_rz('0);
	endtask

	task automatic test_hw_accept();
		load_mask(16'hFFC0); // all groups open
		raise_hw(2); // source 2
		raise_hw(4); // source 5
		raise_hw(8); // source 9
		accept_op(); // 2
		ret_op();
		load_mask(16'hFFC0);
		accept_op(); // 5
		ret_op();
		load_mask(16'hFFC0);
		accept_op(); // 9
		ret_op();
	endtask

	task automatic test_io();
		chan_num_t ch;
		rand_chan(ch);
		load_mask(16'hFFC0);
		io_report({11'd0, ch, 1'b0}); // random channel
		accept_op();
		ret_op();
		load_mask(16'hFFC0);
		io_report(16'h0001); // other cpu at high level
		accept_op();
		ret_op();
		load_mask(16'hFFC0);
		io_report(16'h8001); // other cpu at low level
		accept_op();
		ret_op();
	endtask

	task automatic test_empty();
		accept_op(); // nothing pending
		load_mask('0);
		raise_hw(0); // power fail
		accept_op(); // taken with mask 0
		ret_op();
	endtask

	task automatic test_nesting();
		load_mask(16'hFFC0);
		raise_hw(4); // source 5
		accept_op();
		raise_hw(1); // source 1 nests above 5
		accept_op();
		raise_hw(7); // source 8
		load_mask(16'hFFC0);
		accept_op(); // blocked by 1 and 5
		ret_op(); // 1 released
		accept_op(); // still blocked by 5
		ret_op(); // 5 released
		accept_op(); // now 8
		ret_op();
	endtask

	initial begin
		__clk = 1'b0;
		rst_n = 1'b0;
		op_strobe = 1'b0;
		op_code = OP_LOAD_MASK;
		w = '0;
		hw_irq = '0;
		io_strobe = 1'b0;
		io_data = '0;
		m_rz = '0;
		m_rp = '0;
		m_rm = '0;
		lfsr = 32'h5ad3;
		errors = 0;
		repeat (4) @(posedge __clk);
		@(negedge __clk);
		rst_n = 1'b1;
		test_reset();
		test_write_rz();
		test_hw_accept();
		test_io();
		test_empty();
		test_nesting();
		$display("errors: %0d", errors);
		if (errors == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

// File: verilog/chan_irq_rx.sv
// I/O bus interrupt report receiver
// latches channel and cpu-to-cpu reports, sets rz after the ack delay
`timescale 1ns/1ps

module chan_irq_rx import intr_pkg::*, io_pkg::*; #(
	parameter int DOK_TICKS = 3
) (
	input logic __clk,
	input logic rst_n,
	input logic io_strobe,
	input io_word_t io_data,
	output logic io_ack,
	output src_vec_t bus_set
);

	localparam int CNT_W = $clog2(DOK_TICKS + 1);

	typedef enum logic {IDLE, COUNT} rx_state_t;

	rx_state_t state;
	logic [CNT_W-1:0] cnt; // cycles since the strobe
	io_word_t rdt; // latched report
	chan_num_t chan;
	src_num_t rep_src;
	logic done; // last counting cycle

	assign done = (state == COUNT) && (cnt == CNT_W'(DOK_TICKS));
	assign chan = rdt[RDT_CHAN_MSB:RDT_CHAN_LSB];

	always_comb begin
		if (rdt[RDT_CPU]) rep_src = rdt[RDT_CPU_LOW] ? SRC_CPU_LOW : SRC_CPU_HIGH;
		else rep_src = SRC_CHAN_BASE + src_num_t'(chan);
		bus_set = '0;
		bus_set[rep_src] = done; // rz set on the ack edge
	end

	always_ff @(posedge __clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= IDLE;
			cnt <= '0;
			io_ack <= 1'b0;
		end else begin
			io_ack <= done;
			case (state)
				IDLE: if (io_strobe) begin
					state <= COUNT;
					cnt <= CNT_W'(1);
				end
				COUNT: if (done) state <= IDLE;
				else cnt <= cnt + 1'b1;
				default: state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge __clk) begin
		if (state == IDLE && io_strobe) rdt <= io_data;
	end

	// a report during the count is lost
	a_no_overlap: assert property (
		@(posedge __clk) disable iff (!rst_n)
		(state == COUNT) |-> !io_strobe
	);

endmodule

// File: verilog/intr_cmd_if.sv
// decoded register commands, decode to register bank
// one-cycle strobe, no back-pressure
`timescale 1ns/1ps

interface intr_cmd_if import intr_pkg::*; ();

	logic cmd_valid; // one cycle per command
	intr_op_t cmd_op; // what to do
	word_t cmd_data; // w captured with the strobe

	modport decode (
		output cmd_valid,
		output cmd_op,
		output cmd_data
	);

	modport regs (
		input cmd_valid,
		input cmd_op,
		input cmd_data
	);

endinterface

// File: verilog/intr_decode.sv
// interrupt command decode
// turns cpu op strobes into one-cycle register commands
`timescale 1ns/1ps

module intr_decode import intr_pkg::*; (
	input logic __clk,
	input logic rst_n,
	input logic op_strobe,
	input intr_op_t op_code,
	input word_t w,
	intr_cmd_if.decode cmd
);

	logic soft_nop; // soft int with no level selected

	// nothing to set, so no command goes out
	assign soft_nop = (op_code == OP_SOFT_INT) & ~w[W_SOFT_HIGH] & ~w[W_SOFT_LOW];

	always_ff @(posedge __clk or negedge rst_n) begin
		if (!rst_n) begin
			cmd.cmd_valid <= 1'b0;
		end else begin
			cmd.cmd_valid <= op_strobe & ~soft_nop; // single cycle
		end
	end

	// op and word only matter while cmd_valid is up
	always_ff @(posedge __clk) begin
		if (op_strobe) begin
			cmd.cmd_op <= op_code;
			cmd.cmd_data <= w;
		end
	end

	// cpu must only issue known operations
	a_op_legal: assert property (
		@(posedge __clk) disable iff (!rst_n)
		op_strobe |-> op_code inside {OP_LOAD_MASK, OP_WRITE_RZ, OP_SOFT_INT,
			OP_ACCEPT, OP_RETURN}
	);

endmodule

// File: verilog/intr_pkg.sv
// interrupt unit types and constants
// source vectors are numbered from the msb end, bit 0 is the top priority
package intr_pkg;

	localparam int SRC_N = 32; // request sources in rz
	localparam int MASK_N = 10; // rm groups
	localparam int HW_N = 11; // level inputs

	typedef logic [0:SRC_N-1] src_vec_t; // one bit per source
	typedef logic [4:0] src_num_t; // source number 0..31
	typedef logic [0:MASK_N-1] mask_t; // rm
	typedef logic [0:15] word_t; // cpu data word w
	typedef logic [0:15] user_rz_t; // rz 0..11 then rz 28..31

	typedef enum logic [2:0] {
		OP_LOAD_MASK = 3'd0,
		OP_WRITE_RZ = 3'd1,
		OP_SOFT_INT = 3'd2,
		OP_ACCEPT = 3'd3,
		OP_RETURN = 3'd4
	} intr_op_t;

	// sources covered by each rm bit, source 0 sits in no group
	localparam src_vec_t MASK_GRP [MASK_N] = '{
		32'h4000_0000, 32'h2000_0000, 32'h1000_0000, 32'h0800_0000, // 1 2 3 4
		32'h07F0_0000, 32'h000C_0000, 32'h0003_0000, // 5..11 12..13 14..15
		32'h0000_FC00, 32'h0000_03F0, 32'h0000_000F // 16..21 22..27 28..31
	};
	// last (lowest priority) source of each group
	localparam src_num_t GRP_LAST [MASK_N] = '{
		5'd1, 5'd2, 5'd3, 5'd4, 5'd11, 5'd13, 5'd15, 5'd21, 5'd27, 5'd31
	};

	localparam src_num_t SRC_CPU_HIGH = 5'd3;
	localparam src_num_t SRC_CHAN_BASE = 5'd12;
	localparam src_num_t SRC_CPU_LOW = 5'd29;
	localparam src_num_t SRC_SOFT_HIGH = 5'd30;
	localparam src_num_t SRC_SOFT_LOW = 5'd31;
	localparam src_num_t SRC_UNUSED = 5'd11; // never set
	localparam int W_SOFT_HIGH = 14; // w bits of the soft interrupt op
	localparam int W_SOFT_LOW = 15;

	// hw_irq[i] lands on rz[HW_SRC[i]]
	localparam src_num_t HW_SRC [HW_N] = '{
		5'd0, 5'd1, 5'd2, 5'd4, 5'd5, 5'd6, 5'd7, 5'd8, 5'd9, 5'd10, 5'd11
	};

endpackage

// File: verilog/intr_regs.sv
// interrupt register bank
// rz requests, rm group mask, rp service levels and the priority chain
`timescale 1ns/1ps

module intr_regs import intr_pkg::*; (
	input logic __clk,
	input logic rst_n,
	intr_cmd_if.regs cmd,
	input logic [0:HW_N-1] hw_irq,
	input src_vec_t bus_set,
	output logic irq,
	output user_rz_t bus_rz,
	output mask_t mask,
	output logic acc_valid,
	output logic acc_empty,
	output src_num_t acc_num
);

	src_vec_t rz, rz_nxt; // requests
	src_vec_t rp; // in service
	mask_t rm; // group mask
	src_vec_t imask, sz; // expanded mask, masked requests
	src_vec_t blocked; // at or below highest rp level
	src_vec_t rp_first; // highest level in service, one-hot
	logic sel_ok; // something eligible
	src_num_t sel_num;
	mask_t rm_clr;
	logic ld_cmd, wr_cmd, si_cmd, acc_cmd, ret_cmd;

	assign ld_cmd = cmd.cmd_valid & (cmd.cmd_op == OP_LOAD_MASK);
	assign wr_cmd = cmd.cmd_valid & (cmd.cmd_op == OP_WRITE_RZ);
	assign si_cmd = cmd.cmd_valid & (cmd.cmd_op == OP_SOFT_INT);
	assign acc_cmd = cmd.cmd_valid & (cmd.cmd_op == OP_ACCEPT);
	assign ret_cmd = cmd.cmd_valid & (cmd.cmd_op == OP_RETURN);

	always_comb begin
		imask = '0;
		imask[0] = 1'b1; // power fail is never masked
		for (int g = 0; g < MASK_N; g++) begin
			if (rm[g]) imask = imask | MASK_GRP[g];
		end
	end

	assign sz = rz & imask;
	assign irq = |sz;
	assign bus_rz = {rz[0:11], rz[28:31]}; // channels hidden from the cpu
	assign mask = rm;

	// priority chain stops at the first rp bit
	always_comb begin : p_chain
		logic blk;
		blk = 1'b0;
		sel_ok = 1'b0;
		sel_num = '0;
		for (int k = 0; k < SRC_N; k++) begin
			blk = blk | rp[k];
			blocked[k] = blk;
			if (!blk && sz[k] && !sel_ok) begin
				sel_ok = 1'b1;
				sel_num = src_num_t'(k);
			end
		end
	end

	assign rp_first = rp & ~{1'b0, blocked[0:SRC_N-2]};

	// groups holding the accepted source or anything below it
	always_comb begin
		for (int g = 0; g < MASK_N; g++) rm_clr[g] = (GRP_LAST[g] >= sel_num);
	end

	always_comb begin
		rz_nxt = rz;
		if (wr_cmd) begin
			rz_nxt[0:11] = cmd.cmd_data[0:11];
			rz_nxt[28:31] = cmd.cmd_data[12:15]; // channel bits untouched
		end
		if (si_cmd) begin
			rz_nxt[SRC_SOFT_HIGH] = rz_nxt[SRC_SOFT_HIGH] | cmd.cmd_data[W_SOFT_HIGH];
			rz_nxt[SRC_SOFT_LOW] = rz_nxt[SRC_SOFT_LOW] | cmd.cmd_data[W_SOFT_LOW];
		end
		if (acc_cmd && sel_ok) rz_nxt[sel_num] = 1'b0;
		// level inputs and bus reports win over any clear
		for (int i = 0; i < HW_N; i++) rz_nxt[HW_SRC[i]] = rz_nxt[HW_SRC[i]] | hw_irq[i];
		rz_nxt = rz_nxt | bus_set;
		rz_nxt[SRC_UNUSED] = 1'b0;
	end

	always_ff @(posedge __clk or negedge rst_n) begin
		if (!rst_n) begin
			rz <= '0;
			rm <= '0;
			rp <= '0;
			acc_valid <= 1'b0;
			acc_empty <= 1'b0;
			acc_num <= '0;
		end else begin
			rz <= rz_nxt;
			acc_valid <= acc_cmd;
			if (acc_cmd) begin
				acc_empty <= ~sel_ok;
				acc_num <= sel_num; // 0 when nothing eligible
			end
			if (ld_cmd) rm <= cmd.cmd_data[0:MASK_N-1];
			if (acc_cmd && sel_ok) begin
				rp[sel_num] <= 1'b1;
				rm <= rm & ~rm_clr;
			end
			if (ret_cmd) rp <= rp & ~rp_first; // release top level
		end
	end

	// a new service level always outranks the ones already held
	a_rp_nest: assert property (
		@(posedge __clk) disable iff (!rst_n)
		((rp & ~$past(rp)) & $past(blocked)) == '0
	);

endmodule

// File: verilog/intr_unit.sv
// interrupt unit top level
// decode, register bank, vector encoder and I/O bus report receiver
`timescale 1ns/1ps

module intr_unit import intr_pkg::*, io_pkg::*; #(
	parameter int DOK_TICKS = 3 // bus ack delay in cycles
) (
	input logic __clk,
	input logic rst_n,
	input logic op_strobe, // cpu side
	input intr_op_t op_code,
	input word_t w,
	input logic [0:HW_N-1] hw_irq, // level requests
	input logic io_strobe, // I/O bus
	input io_word_t io_data,
	output logic io_ack,
	output logic irq,
	output user_rz_t bus_rz,
	output mask_t mask,
	output logic vec_valid,
	output logic vec_empty,
	output src_num_t vec_num
);

	intr_cmd_if cmd_bus ();

	logic acc_valid;
	logic acc_empty;
	src_num_t acc_num;
	src_vec_t bus_set; // reported source, one cycle

	intr_decode u_decode (
		.__clk(__clk), .rst_n(rst_n),
		.op_strobe(op_strobe), .op_code(op_code), .w(w),
		.cmd(cmd_bus.decode)
	);

	intr_regs u_regs (
		.__clk(__clk), .rst_n(rst_n),
		.cmd(cmd_bus.regs), .hw_irq(hw_irq), .bus_set(bus_set),
		.irq(irq), .bus_rz(bus_rz), .mask(mask),
		.acc_valid(acc_valid), .acc_empty(acc_empty), .acc_num(acc_num)
	);

	intr_vector u_vector (
		.__clk(__clk), .rst_n(rst_n),
		.acc_valid(acc_valid), .acc_empty(acc_empty), .acc_num(acc_num),
		.vec_valid(vec_valid), .vec_empty(vec_empty), .vec_num(vec_num)
	);

	chan_irq_rx #(.DOK_TICKS(DOK_TICKS)) u_rx (
		.__clk(__clk), .rst_n(rst_n),
		.io_strobe(io_strobe), .io_data(io_data),
		.io_ack(io_ack), .bus_set(bus_set)
	);

endmodule

// File: verilog/intr_vector.sv
// interrupt vector register
// strobes the accepted source number to the cpu and holds it
`timescale 1ns/1ps

module intr_vector import intr_pkg::*; (
	input logic __clk,
	input logic rst_n,
	input logic acc_valid,
	input logic acc_empty,
	input src_num_t acc_num,
	output logic vec_valid,
	output logic vec_empty,
	output src_num_t vec_num
);

	// strobe follows the accept by one edge
	always_ff @(posedge __clk or negedge rst_n) begin
		if (!rst_n) begin
			vec_valid <= 1'b0;
		end else begin
			vec_valid <= acc_valid;
		end
	end

	// number and empty flag hold until the next accept
	// so a slow cpu can still read them
	always_ff @(posedge __clk or negedge rst_n) begin
		if (!rst_n) begin
			vec_empty <= 1'b0;
			vec_num <= '0;
		end else if (acc_valid) begin
			vec_empty <= acc_empty;
			vec_num <= acc_num;
		end
	end

	// accepts are separate cpu ops and never back to back
	a_vec_pulse: assert property (
		@(posedge __clk) disable iff (!rst_n)
		vec_valid |=> !vec_valid
	);

	// empty vector always carries number 0
	a_vec_empty: assert property (
		@(posedge __clk) disable iff (!rst_n)
		(vec_valid && vec_empty) |-> (vec_num == '0)
	);

endmodule

// File: verilog/io_pkg.sv
// I/O bus types for interrupt reports
// rdt bits numbered from the msb end like the cpu word
package io_pkg;

	typedef logic [0:15] io_word_t; // rdt
	typedef logic [3:0] chan_num_t; // channel number

	// report field positions in rdt
	localparam int RDT_CPU = 15; // set: cpu-to-cpu report
	localparam int RDT_CPU_LOW = 0; // cpu report, low priority level
	localparam int RDT_CHAN_MSB = 11; // channel number field
	localparam int RDT_CHAN_LSB = 14;

endpackage
